// File: src/branch_cfg.svh
// core-wide widths and buffer depth; BTB_ENTRIES must stay a power of two for the row index
`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// width of register operands, immediates, program counters and results
// the branch unit is written for a 64-bit datapath and sign handling uses the top bit
`define XLEN_BITS 64

// width of the scoreboard tag that rides along with every issued instruction
// the branch unit only passes it through to the writeback side
`define TRANS_ID_BITS 3

// number of rows in the tagless branch target buffer
// rows are picked by the pc bits right above bit 1 so aliasing is expected
// raising this value widens the index automatically inside the buffer
`define BTB_ENTRIES 16

`endif

// File: src/branch_pkg.sv
// shared types of the branch resolution stage; widths come from branch_cfg.svh and need XLEN_BITS >= 3
`include "branch_cfg.svh"

package branch_pkg;

    // functional unit operators seen by the branch unit
    // ADD stands for any non-branch work that still carries a prediction
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        EQ   = 4'd1,
        NE   = 4'd2,
        LTS  = 4'd3,
        LTU  = 4'd4,
        GES  = 4'd5,
        GEU  = 4'd6,
        JAL  = 4'd7,
        JALR = 4'd8
    } fu_op_e;

    // exception causes follow the privileged spec numbering
    // only the misaligned fetch cause is raised in this stage
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1,
        ILLEGAL_INSTR         = 4'd2,
        BREAKPOINT            = 4'd3
    } exc_cause_e;

    // prediction that fetch attached to the instruction
    // predict_address only matters when predict_taken is set
    typedef struct packed {
        logic                  valid;
        logic                  predict_taken;
        logic [`XLEN_BITS-1:0] predict_address;
    } branch_predict_sbe_t;

    // outcome of a resolved branch as seen by pc generation and the buffer
    // clear marks a prediction that hit an instruction which was no branch
    typedef struct packed {
        logic [`XLEN_BITS-1:0] pc;
        logic [`XLEN_BITS-1:0] target_address;
        logic                  valid;
        logic                  is_taken;
        logic                  is_mispredict;
        logic                  is_lower_16;
        logic                  clear;
    } branch_resolved_t;

    // exception record handed to the commit stage
    // tval holds the pc of the faulting branch and not the bad target
    typedef struct packed {
        exc_cause_e            cause;
        logic [`XLEN_BITS-1:0] tval;
        logic                  valid;
    } exception_t;

endpackage

// File: src/resolve_if.sv
// one resolved branch per cycle with no ready signal; the sink must sample it on the next clock edge
interface resolve_if;

    // resolution payload
    // it is a combinational level that is only meaningful while resolved.valid is high
    // the producer drives it in the same cycle the branch is issued
    branch_pkg::branch_resolved_t resolved;

    // the branch unit produces the resolution
    modport source (
        output resolved
    );

    // the target buffer only observes it
    // there is no back-pressure path so the sink cannot stall the unit
    modport sink (
        input resolved
    );

endinterface

// File: src/branch_unit.sv
// single-cycle branch resolution with no state; always ready, so a caller must not expect back-pressure
`include "branch_cfg.svh"

module branch_unit (
    input  logic [`TRANS_ID_BITS-1:0]  trans_id_i,
    input  branch_pkg::fu_op_e         operator_i,
    input  logic [`XLEN_BITS-1:0]      operand_a_i,
    input  logic [`XLEN_BITS-1:0]      operand_b_i,
    input  logic [`XLEN_BITS-1:0]      imm_i,
    input  logic [`XLEN_BITS-1:0]      pc_i,
    input  logic                       is_compressed_instr_i,
    // high for any valid functional unit so stray predictions can be caught
    input  logic                       fu_valid_i,
    input  logic                       branch_valid_i,
    input  branch_pkg::branch_predict_sbe_t branch_predict_i,
    output logic                       branch_ready_o,
    output logic                       branch_valid_o,
    output logic [`XLEN_BITS-1:0]      branch_result_o,
    output logic [`TRANS_ID_BITS-1:0]  branch_trans_id_o,
    // tells decode that a real branch left the unit
    output logic                       resolve_branch_o,
    output branch_pkg::exception_t     branch_exception_o,
    resolve_if.source                  resolve
);

    localparam int unsigned XLEN = `XLEN_BITS;

    logic [XLEN-1:0]              jump_base;
    logic [XLEN-1:0]              target_address;
    logic [XLEN-1:0]              next_pc;
    logic                         sgn;
    logic                         comparison_result;
    branch_pkg::branch_resolved_t resolved_d;

    // the unit answers in the same cycle so the handshake is a pass-through
    assign branch_trans_id_o = trans_id_i;
    assign branch_valid_o    = branch_valid_i;
    assign branch_ready_o    = 1'b1;

    // JALR jumps relative to rs1 while every other control flow uses the pc
    assign jump_base = (operator_i == branch_pkg::JALR) ? operand_a_i : pc_i;

    // link value and fall-through address depend on the instruction length
    assign next_pc = pc_i + (is_compressed_instr_i ? XLEN'(2) : XLEN'(4));

    // the link register gets the address of the following instruction
    assign branch_result_o = next_pc;

    always_comb begin : compare
        // unsigned compares feed a zero into the extra sign bit
        sgn = !(operator_i inside {branch_pkg::LTU, branch_pkg::GEU});
        case (operator_i)
            branch_pkg::EQ: begin
                comparison_result = (operand_a_i == operand_b_i);
            end
            branch_pkg::NE: begin
                comparison_result = (operand_a_i != operand_b_i);
            end
            branch_pkg::LTS, branch_pkg::LTU: begin
                comparison_result = $signed({sgn & operand_a_i[XLEN-1], operand_a_i})
                                  < $signed({sgn & operand_b_i[XLEN-1], operand_b_i});
            end
            branch_pkg::GES, branch_pkg::GEU: begin
                comparison_result = $signed({sgn & operand_a_i[XLEN-1], operand_a_i})
                                 >= $signed({sgn & operand_b_i[XLEN-1], operand_b_i});
            end
            // jumps and anything else count as taken
            default: begin
                comparison_result = 1'b1;
            end
        endcase
    end

    always_comb begin : target
        target_address = jump_base + imm_i;
        // the spec wants bit 0 of a JALR target forced to zero
        if (operator_i == branch_pkg::JALR) begin
            target_address[0] = 1'b0;
        end
    end

    always_comb begin : mispredict
        resolved_d.pc             = pc_i;
        resolved_d.target_address = '0;
        resolved_d.valid          = branch_valid_i;
        resolved_d.is_taken       = 1'b0;
        resolved_d.is_mispredict  = 1'b0;
        resolved_d.is_lower_16    = 1'b0;
        resolved_d.clear          = 1'b0;
        resolve_branch_o          = 1'b0;

        if (branch_valid_i) begin
            // a full-size branch that straddles a word is predicted at the next word
            // so fetch never has to go back for the upper half
            if (is_compressed_instr_i || !pc_i[1]) begin
                resolved_d.pc = pc_i;
            end else begin
                resolved_d.pc = {pc_i[XLEN-1:2], 2'b00} + XLEN'(4);
            end
            // lower 16 covers a compressed branch in slot 0 and a straddling full branch
            resolved_d.is_lower_16 = (is_compressed_instr_i && !pc_i[1])
                                  || (!is_compressed_instr_i && pc_i[1]);
            resolved_d.target_address = comparison_result ? target_address : next_pc;
            resolved_d.is_taken       = comparison_result;

            // a misaligned target becomes an exception instead of a mispredict
            if (!target_address[0]) begin
                if (branch_predict_i.valid) begin
                    // direction was guessed wrong
                    if (branch_predict_i.predict_taken != comparison_result) begin
                        resolved_d.is_mispredict = 1'b1;
                    end
                    // direction right but fetch went to the wrong place
                    if (branch_predict_i.predict_taken
                        && (target_address != branch_predict_i.predict_address)) begin
                        resolved_d.is_mispredict = 1'b1;
                    end
                end else if (comparison_result) begin
                    // fetch fell through, so any taken branch is a miss
                    resolved_d.is_mispredict = 1'b1;
                end
            end
            resolve_branch_o = 1'b1;
        end else if (fu_valid_i && branch_predict_i.valid) begin
            // a prediction landed on an instruction that is no branch
            // send fetch back to the next pc and drop the stale buffer entry
            resolved_d.valid          = 1'b1;
            resolved_d.is_mispredict  = 1'b1;
            resolved_d.target_address = next_pc;
            resolved_d.clear          = 1'b1;
        end
    end

    assign resolve.resolved = resolved_d;

    // targets must sit on a 2 byte boundary or fetch would fault later
    always_comb begin : exception
        branch_exception_o.cause = branch_pkg::INSTR_ADDR_MISALIGNED;
        branch_exception_o.tval  = pc_i;
        branch_exception_o.valid = branch_valid_i && target_address[0];
    end

endmodule

// File: src/branch_target_buffer.sv
// tagless table indexed by pc bits above bit 1; aliasing rows return another branch's target
`include "branch_cfg.svh"

module branch_target_buffer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    resolve_if.sink               update,
    input  logic [`XLEN_BITS-1:0] lookup_pc_i,
    output logic                  btb_valid_o,
    output logic [`XLEN_BITS-1:0] btb_target_o,
    output logic                  btb_is_lower_16_o
);

    localparam int unsigned ENTRIES  = `BTB_ENTRIES;
    localparam int unsigned IDX_BITS = $clog2(ENTRIES);

    logic [ENTRIES-1:0]          entry_valid_q;
    logic [`XLEN_BITS-1:0]       entry_target_q [ENTRIES];
    logic [ENTRIES-1:0]          entry_lower_16_q;

    logic [IDX_BITS-1:0]         update_idx;
    logic [IDX_BITS-1:0]         lookup_idx;
    logic                        update_en;
    logic                        update_keep;

    // bits 1 and 0 are dropped because at most one branch is predicted per word
    assign update_idx = update.resolved.pc[IDX_BITS+1:2];
    assign lookup_idx = lookup_pc_i[IDX_BITS+1:2];

    // only a mispredict changes the table
    // a correct prediction means the row already holds what fetch needs
    assign update_en = update.resolved.valid && update.resolved.is_mispredict;

    // a taken branch installs its target
    // a not-taken branch or a cleared prediction empties the row
    assign update_keep = update.resolved.is_taken && !update.resolved.clear;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            entry_valid_q <= '0;
        end else if (update_en) begin
            entry_valid_q[update_idx] <= update_keep;
        end
    end

    // a taken mispredict installs its target and lower half flag in the row
    always_ff @(posedge clk_i) begin
        if (update_en && update_keep) begin
            entry_target_q[update_idx]   <= update.resolved.target_address;
            entry_lower_16_q[update_idx] <= update.resolved.is_lower_16;
        end
    end

    // fetch reads the registered table directly
    // a write becomes visible one cycle after the resolving edge
    assign btb_valid_o       = entry_valid_q[lookup_idx];
    assign btb_target_o      = entry_target_q[lookup_idx];
    assign btb_is_lower_16_o = entry_lower_16_q[lookup_idx];

endmodule

// File: src/branch_resolve_top.sv
// wraps the branch unit and target buffer with plain ports; the only state is the buffer table
`include "branch_cfg.svh"

module branch_resolve_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    // issue side
    input  logic [`TRANS_ID_BITS-1:0]  trans_id_i,
    input  branch_pkg::fu_op_e         operator_i,
    input  logic [`XLEN_BITS-1:0]      operand_a_i,
    input  logic [`XLEN_BITS-1:0]      operand_b_i,
    input  logic [`XLEN_BITS-1:0]      imm_i,
    input  logic [`XLEN_BITS-1:0]      pc_i,
    input  logic                       is_compressed_instr_i,
    input  logic                       fu_valid_i,
    input  logic                       branch_valid_i,
    // prediction that came with the instruction
    input  logic                       predict_valid_i,
    input  logic                       predict_taken_i,
    input  logic [`XLEN_BITS-1:0]      predict_address_i,
    // writeback side
    output logic                       branch_ready_o,
    output logic                       branch_valid_o,
    output logic [`XLEN_BITS-1:0]      branch_result_o,
    output logic [`TRANS_ID_BITS-1:0]  branch_trans_id_o,
    output logic                       resolve_branch_o,
    // resolution towards pc generation
    output logic                       resolved_valid_o,
    output logic [`XLEN_BITS-1:0]      resolved_pc_o,
    output logic [`XLEN_BITS-1:0]      resolved_target_o,
    output logic                       resolved_taken_o,
    output logic                       resolved_mispredict_o,
    output logic                       resolved_lower_16_o,
    output logic                       resolved_clear_o,
    // exception towards commit
    output logic                       exc_valid_o,
    output branch_pkg::exc_cause_e     exc_cause_o,
    output logic [`XLEN_BITS-1:0]      exc_tval_o,
    // fetch-side lookup of the target buffer
    input  logic [`XLEN_BITS-1:0]      lookup_pc_i,
    output logic                       btb_valid_o,
    output logic [`XLEN_BITS-1:0]      btb_target_o,
    output logic                       btb_is_lower_16_o
);

    branch_pkg::branch_predict_sbe_t predict;
    branch_pkg::exception_t          branch_exception;

    resolve_if i_resolve ();

    // gather the loose prediction bits into the struct the unit expects
    assign predict.valid           = predict_valid_i;
    assign predict.predict_taken   = predict_taken_i;
    assign predict.predict_address = predict_address_i;

    branch_unit i_branch_unit (
        .trans_id_i            (trans_id_i),
        .operator_i            (operator_i),
        .operand_a_i           (operand_a_i),
        .operand_b_i           (operand_b_i),
        .imm_i                 (imm_i),
        .pc_i                  (pc_i),
        .is_compressed_instr_i (is_compressed_instr_i),
        .fu_valid_i            (fu_valid_i),
        .branch_valid_i        (branch_valid_i),
        .branch_predict_i      (predict),
        .branch_ready_o        (branch_ready_o),
        .branch_valid_o        (branch_valid_o),
        .branch_result_o       (branch_result_o),
        .branch_trans_id_o     (branch_trans_id_o),
        .resolve_branch_o      (resolve_branch_o),
        .branch_exception_o    (branch_exception),
        .resolve               (i_resolve.source)
    );

    branch_target_buffer i_branch_target_buffer (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .update            (i_resolve.sink),
        .lookup_pc_i       (lookup_pc_i),
        .btb_valid_o       (btb_valid_o),
        .btb_target_o      (btb_target_o),
        .btb_is_lower_16_o (btb_is_lower_16_o)
    );

    // the resolution leaves on the same wires the buffer samples
    assign resolved_valid_o      = i_resolve.resolved.valid;
    assign resolved_pc_o         = i_resolve.resolved.pc;
    assign resolved_target_o     = i_resolve.resolved.target_address;
    assign resolved_taken_o      = i_resolve.resolved.is_taken;
    assign resolved_mispredict_o = i_resolve.resolved.is_mispredict;
    assign resolved_lower_16_o   = i_resolve.resolved.is_lower_16;
    assign resolved_clear_o      = i_resolve.resolved.clear;

    assign exc_valid_o = branch_exception.valid;
    assign exc_cause_o = branch_exception.cause;
    assign exc_tval_o  = branch_exception.tval;

endmodule

// File: verification/tb_branch_resolve.sv
// checks branch_resolve_top against a model of the branch rules; needs assertions enabled to check
`include "branch_cfg.svh"

module tb_branch_resolve;

    localparam int XLEN          = `XLEN_BITS;
    localparam int IDX_BITS      = $clog2(`BTB_ENTRIES);
    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 16;
    localparam int RANDOM_CYCLES = 3000;
    // reset, the row sweep, the random part and a margin for the last checks
    localparam int WATCHDOG_TIME = (RESET_CYCLES + `BTB_ENTRIES + RANDOM_CYCLES + 50) * CLK_PERIOD;

    logic                      clk_i;
    logic                      rst_n_i;
    logic [`TRANS_ID_BITS-1:0] trans_id_i;
    branch_pkg::fu_op_e        operator_i;
    logic [XLEN-1:0]           operand_a_i;
    logic [XLEN-1:0]           operand_b_i;
    logic [XLEN-1:0]           imm_i;
    logic [XLEN-1:0]           pc_i;
    logic                      is_compressed_instr_i;
    logic                      fu_valid_i;
    logic                      branch_valid_i;
    logic                      predict_valid_i;
    logic                      predict_taken_i;
    logic [XLEN-1:0]           predict_address_i;
    logic [XLEN-1:0]           lookup_pc_i;
    logic                      branch_ready_o;
    logic                      branch_valid_o;
    logic [XLEN-1:0]           branch_result_o;
    logic [`TRANS_ID_BITS-1:0] branch_trans_id_o;
    logic                      resolve_branch_o;
    logic                      resolved_valid_o;
    logic [XLEN-1:0]           resolved_pc_o;
    logic [XLEN-1:0]           resolved_target_o;
    logic                      resolved_taken_o;
    logic                      resolved_mispredict_o;
    logic                      resolved_lower_16_o;
    logic                      resolved_clear_o;
    logic                      exc_valid_o;
    branch_pkg::exc_cause_e    exc_cause_o;
    logic [XLEN-1:0]           exc_tval_o;
    logic                      btb_valid_o;
    logic [XLEN-1:0]           btb_target_o;
    logic                      btb_is_lower_16_o;

    // expected values of the reference model
    logic                      exp_taken;
    logic [XLEN-1:0]           calc_target;
    logic [XLEN-1:0]           exp_link;
    logic                      exp_is_branch;
    logic                      exp_res_valid;
    logic [XLEN-1:0]           exp_res_pc;
    logic [XLEN-1:0]           exp_res_target;
    logic                      exp_mispredict;
    logic                      exp_lower_16;
    logic                      exp_clear;
    logic                      exp_exc_valid;

    // mirror of the target buffer table
    logic [`BTB_ENTRIES-1:0]   model_valid;
    logic [XLEN-1:0]           model_target [`BTB_ENTRIES];
    logic [`BTB_ENTRIES-1:0]   model_lower_16;

    logic [31:0]               lfsr_state;
    logic [XLEN-1:0]           last_pc;
    int                        error_count;

    branch_resolve_top i_branch_resolve_top (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    // right-shifting Galois form, one step per random bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'hA300_0000;
        end
        return next;
    endfunction

    task automatic draw_bits(input int count, output logic [XLEN-1:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[XLEN-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // operands around the sign boundary where signed and unsigned compares disagree
    function automatic logic [XLEN-1:0] boundary_value(input logic [1:0] sel);
        case (sel)
            2'd0: return {1'b1, {(XLEN-1){1'b0}}};
            2'd1: return {1'b0, {(XLEN-1){1'b1}}};
            2'd2: return '0;
            default: return '1;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        error_count++;
        $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
    endtask

    task automatic drive_random_cycle();
        logic [XLEN-1:0] pick;
        draw_bits(3, pick);
        // one cycle in eight is idle and another one in eight carries a non-branch op
        fu_valid_i     = (pick[2:0] != 3'd0);
        branch_valid_i = (pick[2:0] > 3'd1);
        draw_bits(3, pick);
        operator_i = branch_valid_i ? branch_pkg::fu_op_e'({1'b0, pick[2:0]} + 4'd1)
                                    : branch_pkg::ADD;
        draw_bits(XLEN, operand_a_i);
        draw_bits(XLEN, operand_b_i);
        draw_bits(2, pick);
        if (pick[1:0] == 2'd0) begin
            operand_b_i = operand_a_i;
        end else if (pick[1:0] == 2'd1) begin
            draw_bits(4, pick);
            operand_a_i = boundary_value(pick[1:0]);
            operand_b_i = boundary_value(pick[3:2]);
        end
        draw_bits(XLEN, pc_i);
        draw_bits(XLEN, imm_i);
        // odd targets stay rare so most branches reach the prediction rules
        draw_bits(3, pick);
        if (pick[2:0] != 3'd0) begin
            pc_i[0]  = 1'b0;
            imm_i[0] = 1'b0;
        end
        draw_bits(1, pick);
        is_compressed_instr_i = pick[0];
        draw_bits(`TRANS_ID_BITS, pick);
        trans_id_i = pick[`TRANS_ID_BITS-1:0];
        draw_bits(3, pick);
        predict_valid_i = pick[0];
        predict_taken_i = pick[1];
        draw_bits(XLEN, predict_address_i);
        // half of the predictions point at the real jump address
        if (pick[2]) begin
            predict_address_i = (operator_i == branch_pkg::JALR)
                              ? ((operand_a_i + imm_i) & ~XLEN'(1)) : (pc_i + imm_i);
        end
        // fetch mostly looks at rows that were just written
        draw_bits(2, pick);
        case (pick[1:0])
            2'd0: draw_bits(XLEN, lookup_pc_i);
            2'd1: lookup_pc_i = last_pc;
            2'd2: lookup_pc_i = last_pc + XLEN'(4);
            default: lookup_pc_i = pc_i;
        endcase
        last_pc = pc_i;
    endtask

    always_comb begin : reference_model
        case (operator_i)
            branch_pkg::EQ:  exp_taken = (operand_a_i == operand_b_i);
            branch_pkg::NE:  exp_taken = (operand_a_i != operand_b_i);
            branch_pkg::LTS: exp_taken = ($signed(operand_a_i) < $signed(operand_b_i));
            branch_pkg::LTU: exp_taken = (operand_a_i < operand_b_i);
            branch_pkg::GES: exp_taken = ($signed(operand_a_i) >= $signed(operand_b_i));
            branch_pkg::GEU: exp_taken = (operand_a_i >= operand_b_i);
            default:         exp_taken = 1'b1;
        endcase
        exp_link = pc_i + (is_compressed_instr_i ? XLEN'(2) : XLEN'(4));
        if (operator_i == branch_pkg::JALR) begin
            calc_target = (operand_a_i + imm_i) & ~XLEN'(1);
        end else begin
            calc_target = pc_i + imm_i;
        end
        exp_is_branch  = branch_valid_i;
        exp_res_valid  = branch_valid_i;
        exp_res_pc     = pc_i;
        exp_res_target = exp_link;
        exp_mispredict = 1'b0;
        exp_lower_16   = 1'b0;
        exp_clear      = 1'b0;
        if (branch_valid_i) begin
            // a full-size branch at an odd halfword resolves at the next word
            if (!is_compressed_instr_i && pc_i[1]) begin
                exp_res_pc = (pc_i | XLEN'(3)) + XLEN'(1);
            end
            exp_lower_16   = is_compressed_instr_i ^ pc_i[1];
            exp_res_target = exp_taken ? calc_target : exp_link;
            if (!calc_target[0] && predict_valid_i) begin
                exp_mispredict = (predict_taken_i != exp_taken)
                              || (predict_taken_i && (predict_address_i != calc_target));
            end else if (!calc_target[0]) begin
                exp_mispredict = exp_taken;
            end
        end else if (fu_valid_i && predict_valid_i) begin
            exp_res_valid  = 1'b1;
            exp_mispredict = 1'b1;
            exp_clear      = 1'b1;
        end
        exp_exc_valid = branch_valid_i && calc_target[0];
    end

    // the table changes only on mispredicts, at the edge that ends the cycle
    always @(posedge clk_i) begin : btb_model_update
        if (!rst_n_i) begin
            model_valid <= '0;
        end else if (exp_res_valid && exp_mispredict) begin
            model_valid[exp_res_pc[IDX_BITS+1:2]] <= exp_is_branch && exp_taken;
            if (exp_is_branch && exp_taken) begin
                model_target[exp_res_pc[IDX_BITS+1:2]]   <= exp_res_target;
                model_lower_16[exp_res_pc[IDX_BITS+1:2]] <= exp_lower_16;
            end
        end
    end

    // all outputs are settled half a cycle after the inputs move
    check_ready: assert property (@(negedge clk_i) disable iff (!rst_n_i) branch_ready_o)
        else report_mismatch("branch_ready_o", XLEN'(1), XLEN'(branch_ready_o));
    check_valid: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        branch_valid_o == branch_valid_i)
        else report_mismatch("branch_valid_o", XLEN'(branch_valid_i), XLEN'(branch_valid_o));
    check_trans_id: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        branch_trans_id_o == trans_id_i)
        else report_mismatch("branch_trans_id_o", XLEN'(trans_id_i), XLEN'(branch_trans_id_o));
    check_result: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        branch_result_o == exp_link)
        else report_mismatch("branch_result_o", exp_link, branch_result_o);
    check_resolve: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        resolve_branch_o == exp_is_branch)
        else report_mismatch("resolve_branch_o", XLEN'(exp_is_branch), XLEN'(resolve_branch_o));
    check_res_valid: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        resolved_valid_o == exp_res_valid)
        else report_mismatch("resolved_valid_o", XLEN'(exp_res_valid), XLEN'(resolved_valid_o));
    check_res_pc: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        !exp_res_valid || resolved_pc_o == exp_res_pc)
        else report_mismatch("resolved_pc_o", exp_res_pc, resolved_pc_o);
    check_res_target: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        !exp_res_valid || resolved_target_o == exp_res_target)
        else report_mismatch("resolved_target_o", exp_res_target, resolved_target_o);
    check_res_taken: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        !exp_is_branch || resolved_taken_o == exp_taken)
        else report_mismatch("resolved_taken_o", XLEN'(exp_taken), XLEN'(resolved_taken_o));
    check_mispredict: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        !exp_res_valid || resolved_mispredict_o == exp_mispredict)
        else report_mismatch("resolved_mispredict_o", XLEN'(exp_mispredict),
                             XLEN'(resolved_mispredict_o));
    check_lower_16: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        !exp_is_branch || resolved_lower_16_o == exp_lower_16)
        else report_mismatch("resolved_lower_16_o", XLEN'(exp_lower_16),
                             XLEN'(resolved_lower_16_o));
    check_clear: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        !exp_res_valid || resolved_clear_o == exp_clear)
        else report_mismatch("resolved_clear_o", XLEN'(exp_clear), XLEN'(resolved_clear_o));
    check_exc_valid: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        exc_valid_o == exp_exc_valid)
        else report_mismatch("exc_valid_o", XLEN'(exp_exc_valid), XLEN'(exc_valid_o));
    check_exc_cause: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        !exp_exc_valid || exc_cause_o == branch_pkg::INSTR_ADDR_MISALIGNED)
        else report_mismatch("exc_cause_o", XLEN'(branch_pkg::INSTR_ADDR_MISALIGNED),
                             XLEN'(exc_cause_o));
    check_exc_tval: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        !exp_exc_valid || exc_tval_o == pc_i)
        else report_mismatch("exc_tval_o", pc_i, exc_tval_o);
    check_btb_valid: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        btb_valid_o == model_valid[lookup_pc_i[IDX_BITS+1:2]])
        else report_mismatch("btb_valid_o", XLEN'(model_valid[lookup_pc_i[IDX_BITS+1:2]]),
                             XLEN'(btb_valid_o));
    check_btb_target: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        !model_valid[lookup_pc_i[IDX_BITS+1:2]]
        || btb_target_o == model_target[lookup_pc_i[IDX_BITS+1:2]])
        else report_mismatch("btb_target_o", model_target[lookup_pc_i[IDX_BITS+1:2]],
                             btb_target_o);
    check_btb_lower_16: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        !model_valid[lookup_pc_i[IDX_BITS+1:2]]
        || btb_is_lower_16_o == model_lower_16[lookup_pc_i[IDX_BITS+1:2]])
        else report_mismatch("btb_is_lower_16_o",
                             XLEN'(model_lower_16[lookup_pc_i[IDX_BITS+1:2]]),
                             XLEN'(btb_is_lower_16_o));

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("watchdog expired at %0t before the tests finished", $time);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        lfsr_state            = 32'h93a7ea84;
        error_count           = 0;
        last_pc               = '0;
        rst_n_i               = 1'b0;
        trans_id_i            = '0;
        operator_i            = branch_pkg::ADD;
        operand_a_i           = '0;
        operand_b_i           = '0;
        imm_i                 = '0;
        pc_i                  = '0;
        is_compressed_instr_i = 1'b0;
        fu_valid_i            = 1'b0;
        branch_valid_i        = 1'b0;
        predict_valid_i       = 1'b0;
        predict_taken_i       = 1'b0;
        predict_address_i     = '0;
        lookup_pc_i           = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #(DRIVE_DELAY) rst_n_i = 1'b1;
        // every row must read back empty before any branch resolves
        for (int row = 0; row < `BTB_ENTRIES; row++) begin
            @(posedge clk_i);
            #(DRIVE_DELAY) lookup_pc_i = XLEN'(row) << 2;
        end
        repeat (RANDOM_CYCLES) begin
            @(posedge clk_i);
            #(DRIVE_DELAY) drive_random_cycle();
        end
        @(posedge clk_i);
        #(DRIVE_DELAY) fu_valid_i = 1'b0;
        branch_valid_i = 1'b0;
        @(negedge clk_i);
        @(negedge clk_i);
        $display("run finished with %0d errors after %0d random cycles", error_count,
                 RANDOM_CYCLES);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+src
src/branch_pkg.sv
src/resolve_if.sv
src/branch_unit.sv
src/branch_target_buffer.sv
src/branch_resolve_top.sv
verification/tb_branch_resolve.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for the fail message
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f list.f --top-module tb_branch_resolve

./obj_dir/Vtb_branch_resolve > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
